// File: source/pci_target_pkg.sv
/*
 * Shared definitions for the PCI memory target.
 * Holds the bus widths, the command and state encodings, and the parity helper.
 */
package pci_target_pkg;

  // Width of the multiplexed address/data bus
  localparam int AD_W  = 32;
  // Width of the command / byte-enable lines
  localparam int CBE_W = 4;

  typedef logic [AD_W-1:0]  ad_t;
  // Byte enables are active low on the bus, the command is taken as driven
  typedef logic [CBE_W-1:0] cbe_t;

  // Command codes as seen on C/BE during the address phase
  // IO codes are named only so that decode can turn them away
  typedef enum logic [3:0] {
    IO_READ   = 4'b0010,
    IO_WRITE  = 4'b0011,
    MEM_READ  = 4'b0110,
    MEM_WRITE = 4'b0111
  } pci_cmd_e;

  typedef enum logic [2:0] {
    IDLE       = 3'd0,
    WB_ACCESS  = 3'd1,
    DATA_PHASE = 3'd2,
    TURNAROUND = 3'd3
  } target_state_e;

  // PAR makes the number of ones over AD, C/BE and PAR even
  function automatic logic even_par(input ad_t ad, input cbe_t cbe);
    return (^ad) ^ (^cbe);
  endfunction

endpackage

// File: source/wb_if.sv
/*
 * Wishbone classic link between the target control and the local memory.
 * Single word accesses, ack returned by the slave.
 */
`timescale 1ns/1ns

interface wb_if import pci_target_pkg::*; #(
  parameter int MEM_AW = 6
) ();

  logic              cyc;
  logic              stb;
  logic              we;
  // Word address inside the memory window
  logic [MEM_AW-1:0] adr;
  // Byte selects, active high
  logic [CBE_W-1:0]  sel;
  ad_t               dat_w;
  ad_t               dat_r;
  logic              ack;

  // Control side starts the cycle and waits for ack
  modport master (output cyc, stb, we, adr, sel, dat_w, input dat_r, ack);

  // Memory side answers every strobe with one ack
  modport slave (input cyc, stb, we, adr, sel, dat_w, output dat_r, ack);

endinterface

// File: source/pci_sample_if.sv
/*
 * Registered copy of the PCI bus from the previous clock edge,
 * together with the parity check of that previous cycle.
 */
`timescale 1ns/1ns

interface pci_sample_if import pci_target_pkg::*; ();

  // Levels are kept active low, exactly as sampled from the bus
  ad_t  ad_prev;
  cbe_t cbe_l_prev;
  logic frame_prev;
  logic irdy_prev;
  // PAR at this edge did not match the data of the edge before
  logic par_err;

  modport source (output ad_prev, cbe_l_prev, frame_prev, irdy_prev, par_err);

  modport sink (input ad_prev, cbe_l_prev, frame_prev, irdy_prev, par_err);

endinterface

// File: source/bus_sampler.sv
/*
 * Input sampler for the PCI bus.
 * Keeps the previous-cycle copy of AD, C/BE, FRAME and IRDY and
 * checks the PAR that arrives one cycle after its data.
 */
`timescale 1ns/1ns

module bus_sampler import pci_target_pkg::*; (
  input  logic pci_ext_clk,
  input  logic pci_reset_comb,
  input  ad_t  ad_in,
  input  cbe_t cbe_l,
  input  logic frame_l,
  input  logic irdy_l,
  input  logic par_in,
  pci_sample_if.source smp
);

  // ==========================================================
  // Control samples
  // ==========================================================

  // FRAME and IRDY come out of reset as an idle bus
  always_ff @(posedge pci_ext_clk or posedge pci_reset_comb)
  begin
    if (pci_reset_comb)
    begin
      smp.frame_prev <= 1'b1;
      smp.irdy_prev  <= 1'b1;
      smp.par_err    <= 1'b0;
    end
    else
    begin
      smp.frame_prev <= frame_l;
      smp.irdy_prev  <= irdy_l;
      // PAR belongs to the AD and C/BE sampled one edge earlier
      // The result is only meaningful after a write data transfer
      smp.par_err    <= par_in != even_par(smp.ad_prev, smp.cbe_l_prev);
    end
  end

  // ==========================================================
  // Data samples
  // ==========================================================

  // Address, command, data and byte enables of the last edge
  always_ff @(posedge pci_ext_clk)
  begin
    smp.ad_prev    <= ad_in;
    smp.cbe_l_prev <= cbe_l;
  end

endmodule

// File: source/target_control.sv
/*
 * Transaction control for the PCI memory target.
 * Decodes the address phase, runs one Wishbone access per hit, drives
 * DEVSEL/TRDY/STOP through the data phase and turnaround, and times PERR.
 */
`timescale 1ns/1ns

module target_control import pci_target_pkg::*; #(
  parameter logic [AD_W-1:0] BAR_BASE = 32'h1000_0000,
  parameter int              MEM_AW   = 6
) (
  input  logic pci_ext_clk,
  input  logic pci_reset_comb,
  input  logic frame_l,
  pci_sample_if.sink smp,
  wb_if.master       wb,
  output ad_t  rd_data,
  output logic rd_valid,
  output logic devsel_l,
  output logic trdy_l,
  output logic stop_l,
  output logic target_oe,
  output logic perr_l,
  output logic perr_oe
);

  target_state_e state;
  // The address phase was sampled at the last edge
  logic     addr_vld;
  // TRDY as it was seen on the bus at the last edge
  logic     trdy_smp;
  // A write transfer finished, its PAR is checked one edge later
  logic     wr_chk;
  logic     perr_q;
  pci_cmd_e cmd;
  logic     cmd_hit;
  logic     win_hit;
  logic     start;
  logic     xfer_done;
  logic     wr_go;

  // ==========================================================
  // Address decode
  // ==========================================================

  // The command is driven on C/BE as is, not inverted
  assign cmd = pci_cmd_e'(smp.cbe_l_prev);

  // Only the bits above the window are compared against the base
  assign win_hit = smp.ad_prev[AD_W-1:MEM_AW+2] == BAR_BASE[AD_W-1:MEM_AW+2];

  always_comb
  begin
    case (cmd)
      MEM_READ, MEM_WRITE: cmd_hit = 1'b1;
      // No IO space in this device, so IO cycles are never claimed
      IO_READ, IO_WRITE:   cmd_hit = 1'b0;
      default:             cmd_hit = 1'b0;
    endcase
  end

  // FRAME falls on an idle bus, this edge is the address phase
  assign start = ~frame_l & smp.frame_prev & smp.irdy_prev;

  // IRDY and TRDY were both low at the last edge
  assign xfer_done = ~smp.irdy_prev & ~trdy_smp;

  // Write data is valid once IRDY has been sampled low
  assign wr_go = (state == WB_ACCESS) && wb.we && !wb.cyc && !smp.irdy_prev;

  // ==========================================================
  // Transaction FSM
  // ==========================================================

  always_ff @(posedge pci_ext_clk or posedge pci_reset_comb)
  begin
    if (pci_reset_comb)
    begin
      state     <= IDLE;
      addr_vld  <= 1'b0;
      devsel_l  <= 1'b1;
      trdy_l    <= 1'b1;
      stop_l    <= 1'b1;
      target_oe <= 1'b0;
      rd_valid  <= 1'b0;
      wb.cyc    <= 1'b0;
      wb.stb    <= 1'b0;
      wb.we     <= 1'b0;
    end
    else
    begin
      addr_vld <= (state == IDLE) && start;
      case (state)
        IDLE:
        begin
          // Claim the cycle one clock after the address phase
          if (addr_vld && cmd_hit && win_hit)
          begin
            devsel_l  <= 1'b0;
            target_oe <= 1'b1;
            wb.we     <= cmd == MEM_WRITE;
            // A read can start at once, a write waits for its data
            wb.cyc    <= cmd == MEM_READ;
            wb.stb    <= cmd == MEM_READ;
            state     <= WB_ACCESS;
          end
        end
        WB_ACCESS:
        begin
          if (wb.cyc && wb.ack)
          begin
            wb.cyc   <= 1'b0;
            wb.stb   <= 1'b0;
            trdy_l   <= 1'b0;
            // Initiator still wants more, disconnect on this phase
            stop_l   <= frame_l;
            rd_valid <= ~wb.we;
            state    <= DATA_PHASE;
          end
          else if (wr_go)
          begin
            wb.cyc <= 1'b1;
            wb.stb <= 1'b1;
          end
        end
        DATA_PHASE:
        begin
          if (xfer_done)
          begin
            devsel_l <= 1'b1;
            trdy_l   <= 1'b1;
            stop_l   <= 1'b1;
            rd_valid <= 1'b0;
            state    <= TURNAROUND;
          end
        end
        TURNAROUND:
        begin
          // Signals are high now, so the drivers can let go
          target_oe <= 1'b0;
          state     <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Wishbone payload and read data need no reset
  always_ff @(posedge pci_ext_clk)
  begin
    if (state == IDLE && addr_vld)
    begin
      wb.adr <= smp.ad_prev[MEM_AW+1:2];
      wb.sel <= '1;
    end
    if (wr_go)
    begin
      wb.dat_w <= smp.ad_prev;
      wb.sel   <= ~smp.cbe_l_prev;
    end
    if (state == WB_ACCESS && wb.cyc && wb.ack)
      rd_data <= wb.dat_r;
  end

  // ==========================================================
  // PERR timing
  // ==========================================================

  // Transfer at edge T is seen here at T+1, PAR is checked at T+1 and
  // PERR is driven after T+2 for one cycle
  always_ff @(posedge pci_ext_clk or posedge pci_reset_comb)
  begin
    if (pci_reset_comb)
    begin
      trdy_smp <= 1'b1;
      wr_chk   <= 1'b0;
      perr_q   <= 1'b0;
    end
    else
    begin
      trdy_smp <= trdy_l;
      wr_chk   <= (state == DATA_PHASE) && xfer_done && wb.we;
      perr_q   <= wr_chk && smp.par_err;
    end
  end

  assign perr_l  = ~perr_q;
  assign perr_oe = perr_q;

  // DEVSEL is only ever driven low while its output enable is on
  a_devsel_oe : assert property (@(posedge pci_ext_clk) disable iff (pci_reset_comb)
    !devsel_l |-> target_oe);

  // A strobe only starts inside a bus cycle
  a_stb_cyc : assert property (@(posedge pci_ext_clk) disable iff (pci_reset_comb)
    $rose(wb.stb) |-> wb.cyc);

endmodule

// File: source/ad_parity_driver.sv
/*
 * Read data driver for AD and PAR.
 * PAR is registered one cycle behind AD, over AD and the C/BE of the initiator.
 */
`timescale 1ns/1ns

module ad_parity_driver import pci_target_pkg::*; (
  input  logic pci_ext_clk,
  input  logic pci_reset_comb,
  input  ad_t  rd_data,
  input  logic rd_valid,
  input  cbe_t cbe_l,
  output ad_t  ad_out,
  output logic ad_oe,
  output logic par_out,
  output logic par_oe
);

  // ==========================================================
  // AD drive
  // ==========================================================

  // Control holds the read word stable through the whole data phase
  assign ad_oe  = rd_valid;
  // Keep the output quiet while the bus belongs to someone else
  assign ad_out = rd_valid ? rd_data : '0;

  // ==========================================================
  // PAR drive
  // ==========================================================

  // The enable trails AD by one clock, as does the parity itself
  always_ff @(posedge pci_ext_clk or posedge pci_reset_comb)
  begin
    if (pci_reset_comb)
      par_oe <= 1'b0;
    else
      par_oe <= ad_oe;
  end

  // C/BE is driven by the initiator even during a read, so it is part of PAR
  always_ff @(posedge pci_ext_clk)
  begin
    par_out <= even_par(ad_out, cbe_l);
  end

  // PAR follows every driven AD word one cycle later with matching parity
  a_par_follow : assert property (@(posedge pci_ext_clk) disable iff (pci_reset_comb)
    (par_oe == $past(ad_oe)) &&
    (!par_oe || par_out == even_par($past(ad_out), $past(cbe_l))));

endmodule

// File: source/local_memory.sv
/*
 * On-chip word memory behind a Wishbone classic slave.
 * Byte-selected writes, registered reads, one ack per strobe.
 */
`timescale 1ns/1ns

module local_memory import pci_target_pkg::*; #(
  parameter int MEM_AW = 6
) (
  input  logic pci_ext_clk,
  input  logic pci_reset_comb,
  wb_if.slave  wb
);

  localparam int DEPTH = 1 << MEM_AW;

  ad_t  mem [DEPTH];
  // A new request, the one already acked is not taken twice
  logic req;

  assign req = wb.cyc & wb.stb & ~wb.ack;

  // Ack comes one cycle after the strobe and lasts one cycle
  always_ff @(posedge pci_ext_clk or posedge pci_reset_comb)
  begin
    if (pci_reset_comb)
      wb.ack <= 1'b0;
    else
      wb.ack <= req;
  end

  // Storage and read data carry no reset
  always_ff @(posedge pci_ext_clk)
  begin
    if (req && wb.we)
    begin
      for (int b = 0; b < CBE_W; b++)
      begin
        if (wb.sel[b])
          mem[wb.adr][8*b +: 8] <= wb.dat_w[8*b +: 8];
      end
    end
    // Read data shows up together with ack
    if (req)
      wb.dat_r <= mem[wb.adr];
  end

  // Each strobe gets a single cycle of ack
  a_ack_single : assert property (@(posedge pci_ext_clk) disable iff (pci_reset_comb)
    wb.ack |=> !wb.ack);

endmodule

// File: source/pci_target_top.sv
/*
 * Top level of the PCI memory target.
 * Splits every driven PCI signal into separate out and enable ports.
 */
`timescale 1ns/1ns

module pci_target_top import pci_target_pkg::*; #(
  parameter logic [AD_W-1:0] BAR_BASE = 32'h1000_0000,
  parameter int              MEM_AW   = 6
) (
  input  logic pci_ext_clk,
  input  logic pci_reset_comb,
  input  ad_t  ad_in,
  input  cbe_t cbe_l,
  input  logic frame_l,
  input  logic irdy_l,
  input  logic par_in,
  output ad_t  ad_out,
  output logic ad_oe,
  output logic par_out,
  output logic par_oe,
  output logic devsel_l,
  output logic trdy_l,
  output logic stop_l,
  // One enable for DEVSEL, TRDY and STOP together
  output logic target_oe,
  output logic perr_l,
  output logic perr_oe
);

  // Read word from control to the AD driver
  ad_t  rd_data;
  logic rd_valid;

  wb_if #(.MEM_AW(MEM_AW)) u_wb ();
  pci_sample_if u_smp ();

  bus_sampler u_bus_sampler (
    .pci_ext_clk    (pci_ext_clk),
    .pci_reset_comb (pci_reset_comb),
    .ad_in          (ad_in),
    .cbe_l          (cbe_l),
    .frame_l        (frame_l),
    .irdy_l         (irdy_l),
    .par_in         (par_in),
    .smp            (u_smp.source)
  );

  target_control #(
    .BAR_BASE (BAR_BASE),
    .MEM_AW   (MEM_AW)
  ) u_target_control (
    .pci_ext_clk    (pci_ext_clk),
    .pci_reset_comb (pci_reset_comb),
    .frame_l        (frame_l),
    .smp            (u_smp.sink),
    .wb             (u_wb.master),
    .rd_data        (rd_data),
    .rd_valid       (rd_valid),
    .devsel_l       (devsel_l),
    .trdy_l         (trdy_l),
    .stop_l         (stop_l),
    .target_oe      (target_oe),
    .perr_l         (perr_l),
    .perr_oe        (perr_oe)
  );

  ad_parity_driver u_ad_parity_driver (
    .pci_ext_clk    (pci_ext_clk),
    .pci_reset_comb (pci_reset_comb),
    .rd_data        (rd_data),
    .rd_valid       (rd_valid),
    .cbe_l          (cbe_l),
    .ad_out         (ad_out),
    .ad_oe          (ad_oe),
    .par_out        (par_out),
    .par_oe         (par_oe)
  );

  local_memory #(.MEM_AW(MEM_AW)) u_local_memory (
    .pci_ext_clk    (pci_ext_clk),
    .pci_reset_comb (pci_reset_comb),
    .wb             (u_wb.slave)
  );

endmodule

// File: verif/tb_clock_gen.sv
/*
 * Clock and reset source for the PCI target testbench.
 * Free-running clock, reset held for a fixed number of cycles.
 */
`timescale 1ns/1ns

module tb_clock_gen #(
  parameter int PERIOD       = 20,
  parameter int RESET_CYCLES = 10
) (
  output logic pci_ext_clk,
  output logic pci_reset_comb
);

  initial
  begin
    pci_ext_clk = 1'b0;
    forever #(PERIOD / 2) pci_ext_clk = ~pci_ext_clk;
  end

  // Reset is released on a falling edge, well away from the sampling edge
  initial
  begin
    pci_reset_comb = 1'b1;
    repeat (RESET_CYCLES) @(negedge pci_ext_clk);
    pci_reset_comb = 1'b0;
  end

endmodule

// File: verif/tb_checker.sv
/*
 * Bus monitor for the PCI target testbench.
 * Samples the DUT ports at every rising edge and compares them with the
 * timing and data that the current transaction should produce.
 */
`timescale 1ns/1ns

module tb_checker (
  input  logic        pci_ext_clk,
  input  logic        pci_reset_comb,
  input  logic [31:0] ad_out,
  input  logic [3:0]  cbe_l,
  input  logic        ad_oe, par_out, par_oe,
  input  logic        frame_l, irdy_l,
  input  logic        devsel_l, trdy_l, stop_l, target_oe,
  input  logic        perr_l, perr_oe,
  // Expected results of the transaction whose address phase comes next
  input  logic        exp_hit, exp_read, exp_perr, exp_stop,
  input  logic [31:0] exp_data,
  output int          errors
);

  int          err_cnt = 0;
  // Edges counted from the address phase E0, and the edge of the transfer
  int          cnt;
  int          xfer_cnt;
  logic        frame_q, irdy_q, ad_oe_q, par_q;
  logic        active, xfer_seen, perr_exp;
  logic        t_hit, t_read, t_perr, t_stop;
  logic [31:0] t_data;

  assign errors = err_cnt;

  task automatic verify_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("ERROR %s: got %h expected %h at %0t", name, got, exp, $time);
      err_cnt++;
    end
  endtask

  task automatic compare_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("ERROR %s: got %h expected %h at %0t", name, got, exp, $time);
      err_cnt++;
    end
  endtask

  // ==========================================================
  // Edge sampling, values seen here are the ones the edge captures
  // ==========================================================
  always @(posedge pci_ext_clk)
  begin
    if (pci_reset_comb)
    begin
      // Every enable off and every active-low strobe released
      verify_bit("ad_oe", ad_oe, 1'b0);
      verify_bit("par_oe", par_oe, 1'b0);
      verify_bit("target_oe", target_oe, 1'b0);
      verify_bit("perr_oe", perr_oe, 1'b0);
      verify_bit("devsel_l", devsel_l, 1'b1);
      verify_bit("trdy_l", trdy_l, 1'b1);
      verify_bit("stop_l", stop_l, 1'b1);
      verify_bit("perr_l", perr_l, 1'b1);
      frame_q   = 1'b1;
      irdy_q    = 1'b1;
      ad_oe_q   = 1'b0;
      par_q     = 1'b0;
      active    = 1'b0;
      xfer_seen = 1'b0;
      cnt       = 0;
      xfer_cnt  = 0;
    end
    else
    begin
      // FRAME falling on an idle bus is the address phase
      if (!frame_l && frame_q && irdy_q)
      begin
        active    = 1'b1;
        xfer_seen = 1'b0;
        cnt       = 0;
        t_hit     = exp_hit;
        t_read    = exp_read;
        t_perr    = exp_perr;
        t_stop    = exp_stop;
        t_data    = exp_data;
      end
      else if (cnt < 1000)
        cnt++;

      // PAR and its enable trail AD by exactly one clock
      verify_bit("par_oe", par_oe, ad_oe_q);
      if (ad_oe_q)
        verify_bit("par_out", par_out, par_q);

      if (!devsel_l && !target_oe)
      begin
        $display("DEVSEL was driven low while the target enable was off at %0t", $time);
        err_cnt++;
      end

      if (active)
      begin
        // A hit is claimed one clock after E0, a miss is never claimed
        if (t_hit && cnt == 1)
          verify_bit("devsel_l", devsel_l, 1'b1);
        if (t_hit && cnt == 2)
          verify_bit("devsel_l", devsel_l, 1'b0);
        if (!t_hit && cnt <= 5)
          verify_bit("devsel_l", devsel_l, 1'b1);
        // With FRAME held the target disconnects on its only data phase
        verify_bit("stop_l", stop_l, !(t_stop && !trdy_l));
        if (!irdy_l && !trdy_l && !xfer_seen)
        begin
          xfer_seen = 1'b1;
          xfer_cnt  = cnt;
          // AD is driven by the target only on a read
          verify_bit("ad_oe", ad_oe, t_read);
          if (t_read)
            compare_word("ad_out", ad_out, t_data);
        end
        // Strobes go high first, the shared enable drops one clock later
        if (xfer_seen && cnt == xfer_cnt + 2)
        begin
          verify_bit("devsel_l", devsel_l, 1'b1);
          verify_bit("trdy_l", trdy_l, 1'b1);
          verify_bit("stop_l", stop_l, 1'b1);
          verify_bit("ad_oe", ad_oe, 1'b0);
          verify_bit("target_oe", target_oe, 1'b1);
        end
        if (xfer_seen && cnt == xfer_cnt + 3)
          verify_bit("target_oe", target_oe, 1'b0);
      end

      // One PERR cycle, driven after the second edge past a bad write transfer
      perr_exp = active && t_perr && xfer_seen && (cnt == xfer_cnt + 3);
      verify_bit("perr_l", perr_l, !perr_exp);
      verify_bit("perr_oe", perr_oe, perr_exp);

      frame_q = frame_l;
      irdy_q  = irdy_l;
      ad_oe_q = ad_oe;
      // Even parity over the driven word and the initiator's byte enables
      par_q   = (^ad_out) ^ (^cbe_l);
    end
  end

endmodule

// File: verif/tb_top.sv
/*
 * Testbench top for the PCI memory target.
 * Plays the PCI initiator for every transaction in the golden file and
 * leaves the comparing to the bus monitor.
 */
`timescale 1ns/1ns

module tb_top import pci_target_pkg::*; ();

  localparam int CLK_PERIOD = 20;
  localparam int NUM_TXN    = 16;
  // Words per golden line
  localparam int FIELDS     = 8;

  logic        pci_ext_clk;
  logic        pci_reset_comb;
  logic [31:0] ad_in = '0;
  logic [3:0]  cbe_l = '0;
  logic        frame_l = 1'b1;
  logic        irdy_l = 1'b1;
  logic        par_in = 1'b0;
  // Set while the initiator deliberately sends wrong write parity
  logic        par_flip = 1'b0;
  logic [31:0] ad_out;
  logic        ad_oe, par_out, par_oe;
  logic        devsel_l, trdy_l, stop_l, target_oe, perr_l, perr_oe;
  logic        exp_hit, exp_read, exp_perr, exp_stop;
  logic [31:0] exp_data;
  logic [31:0] gold [NUM_TXN * FIELDS];
  integer      seed;
  int          drv_errors;
  int          chk_errors;

  tb_clock_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(10)) u_clock_gen (
    .pci_ext_clk    (pci_ext_clk),
    .pci_reset_comb (pci_reset_comb)
  );

  pci_target_top u_dut (
    .pci_ext_clk (pci_ext_clk), .pci_reset_comb (pci_reset_comb),
    .ad_in       (ad_in),       .cbe_l          (cbe_l),
    .frame_l     (frame_l),     .irdy_l         (irdy_l),
    .par_in      (par_in),      .ad_out         (ad_out),
    .ad_oe       (ad_oe),       .par_out        (par_out),
    .par_oe      (par_oe),      .devsel_l       (devsel_l),
    .trdy_l      (trdy_l),      .stop_l         (stop_l),
    .target_oe   (target_oe),   .perr_l         (perr_l),
    .perr_oe     (perr_oe)
  );

  tb_checker u_checker (
    .pci_ext_clk (pci_ext_clk), .pci_reset_comb (pci_reset_comb),
    .ad_out      (ad_out),      .cbe_l          (cbe_l),
    .ad_oe       (ad_oe),       .par_out        (par_out),
    .par_oe      (par_oe),      .frame_l        (frame_l),
    .irdy_l      (irdy_l),      .devsel_l       (devsel_l),
    .trdy_l      (trdy_l),      .stop_l         (stop_l),
    .target_oe   (target_oe),   .perr_l         (perr_l),
    .perr_oe     (perr_oe),     .exp_hit        (exp_hit),
    .exp_read    (exp_read),    .exp_perr       (exp_perr),
    .exp_stop    (exp_stop),    .exp_data       (exp_data),
    .errors      (chk_errors)
  );

  // PAR covers the AD and C/BE of the previous clock
  always @(negedge pci_ext_clk)
  begin
    par_in <= (^ad_in) ^ (^cbe_l) ^ par_flip;
  end

  // ==========================================================
  // One single-data-phase transaction from golden line idx
  // ==========================================================
  task automatic run_transaction(input int idx);
    logic [3:0] cmd;
    logic       is_wr;
    logic       hit;
    logic       hold;
    logic       bad;
    int         waits;
    int         n;
    cmd   = gold[idx * FIELDS][3:0];
    is_wr = (cmd == MEM_WRITE) || (cmd == IO_WRITE);
    bad   = gold[idx * FIELDS + 4][0];
    hold  = gold[idx * FIELDS + 5][0];
    hit   = gold[idx * FIELDS + 6][0];
    // Up to two IRDY wait states, so FRAME is gone before a read is acked
    waits = $unsigned($random(seed)) % 3;
    @(negedge pci_ext_clk);
    frame_l  <= 1'b0;
    ad_in    <= gold[idx * FIELDS + 1];
    cbe_l    <= cmd;
    exp_hit  <= hit;
    exp_read <= cmd == MEM_READ;
    exp_perr <= bad & is_wr;
    exp_stop <= hold;
    exp_data <= gold[idx * FIELDS + 7];
    @(negedge pci_ext_clk);
    // Data phase, the target owns AD on a read
    ad_in <= is_wr ? gold[idx * FIELDS + 3] : 32'h0;
    cbe_l <= gold[idx * FIELDS + 2][3:0];
    repeat (waits) @(negedge pci_ext_clk);
    irdy_l   <= 1'b0;
    par_flip <= bad & is_wr;
    if (!hold)
      frame_l <= 1'b1;
    if (hit)
    begin
      n = 0;
      // TRDY seen now is what the target shows at the coming edge
      while (trdy_l !== 1'b0 && n < 20)
      begin
        @(negedge pci_ext_clk);
        n++;
      end
      if (trdy_l !== 1'b0)
      begin
        $display("Target never asserted TRDY in transaction %0d", idx);
        drv_errors++;
      end
      @(negedge pci_ext_clk);
    end
    else
      repeat (6) @(negedge pci_ext_clk);
    frame_l  <= 1'b1;
    irdy_l   <= 1'b1;
    ad_in    <= 32'h0;
    cbe_l    <= 4'h0;
    par_flip <= 1'b0;
    // Room for turnaround and a PERR pulse before the next address phase
    repeat (4) @(negedge pci_ext_clk);
  endtask

  initial
  begin
    seed       = 92105;
    drv_errors = 0;
    exp_hit    = 1'b0;
    exp_read   = 1'b0;
    exp_perr   = 1'b0;
    exp_stop   = 1'b0;
    exp_data   = 32'h0;
    $readmemh("verif/pci_golden.txt", gold);
    @(negedge pci_reset_comb);
    repeat (2) @(negedge pci_ext_clk);
    for (int i = 0; i < NUM_TXN; i++)
      run_transaction(i);
    repeat (4) @(negedge pci_ext_clk);
    $display("Errors: %0d in checks, %0d in the initiator", chk_errors, drv_errors);
    if (chk_errors == 0 && drv_errors == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

  // Forty cycles for each transaction on top of the reset period
  initial
  begin
    #((NUM_TXN * 40 + 10) * CLK_PERIOD);
    $display("Watchdog expired before all transactions were done");
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

// File: verif/pci_golden.txt
// cmd addr cbe_l wdata bad_par hold_frame hit rd_data, all hex
// cbe_l is the active-low byte enable of the data phase
7 10000010 0 A5A5A5A5 0 0 1 00000000
6 10000010 0 00000000 0 0 1 A5A5A5A5
7 10000010 A 11223344 0 0 1 00000000
6 10000010 0 00000000 0 0 1 A522A544
7 10000040 0 DEADBEEF 1 0 1 00000000
6 10000040 0 00000000 0 0 1 DEADBEEF
7 10000080 0 CAFEF00D 0 1 1 00000000
6 10000080 0 00000000 0 1 1 CAFEF00D
6 20000010 0 00000000 0 0 0 00000000
7 10000100 0 12345678 0 0 0 00000000
2 10000010 0 00000000 0 0 0 00000000
3 10000010 0 55AA55AA 0 0 0 00000000
6 10000010 0 00000000 0 0 1 A522A544
7 100000FC 0 0F0F0F0F 0 0 1 00000000
7 100000FC 3 87654321 0 0 1 00000000
6 100000FC 0 00000000 0 0 1 87650F0F

// File: vlog.f
source/pci_target_pkg.sv
source/wb_if.sv
source/pci_sample_if.sv
source/bus_sampler.sv
source/target_control.sv
source/ad_parity_driver.sv
source/local_memory.sv
source/pci_target_top.sv
verif/tb_clock_gen.sv
verif/tb_checker.sv
verif/tb_top.sv

// File: Makefile
# Verilator build and run of the PCI memory target testbench

TOP = tb_top

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ns -f vlog.f \
		--top-module $(TOP) -Mdir obj_dir -o $(TOP)

run: compile
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "PASS: all tests"

clean:
	rm -rf obj_dir
